//--- logic/cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN       = 64;
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_IMM,
        WB_PC4,
        WB_MEM
    } wb_sel_e;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EX_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        branch;
        logic        jal;
        logic        jalr;
        logic        alu_src_imm;
        alu_op_e     alu_op;
        wb_sel_e     wb_sel;
        logic [2:0]  funct3;   // branch condition
    } ctrl_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        wb_sel_e               wb_sel;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       result;     // also the data memory address
        logic [XLEN-1:0]       store_data;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       imm;
    } ex_mem_t;

    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        wb_sel_e               wb_sel;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       result;
        logic [XLEN-1:0]       load_data;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       imm;
    } mem_wb_t;

endpackage

//--- logic/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        stall,
    input  logic                        redirect,
    input  logic [cpu_pkg::XLEN-1:0]    redirect_pc,
    input  logic [cpu_pkg::INST_W-1:0]  inst,
    output logic [cpu_pkg::XLEN-1:0]    pc_out,
    output logic [cpu_pkg::INST_W-1:0]  if_id_inst,
    output logic [cpu_pkg::XLEN-1:0]    if_id_pc,
    output logic                        if_id_valid
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_out <= cpu_pkg::RESET_PC;
        end else if (redirect) begin   // redirect wins over stall
            pc_out <= redirect_pc;
        end else if (!stall) begin
            pc_out <= pc_out + 64'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || redirect) begin
            if_id_valid <= 1'b0;   // kill the fetch in flight
        end else if (!stall) begin
            if_id_valid <= 1'b1;
            if_id_inst  <= inst;
            if_id_pc    <= pc_out;
        end
    end

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            stall,
    input  logic                            redirect,
    input  logic [cpu_pkg::INST_W-1:0]      if_id_inst,
    input  logic [cpu_pkg::XLEN-1:0]        if_id_pc,
    input  logic                            if_id_valid,
    input  logic [cpu_pkg::XLEN-1:0]        rs1_data,
    input  logic [cpu_pkg::XLEN-1:0]        rs2_data,
    output logic [cpu_pkg::REG_ADDR_W-1:0]  rs1_addr,
    output logic [cpu_pkg::REG_ADDR_W-1:0]  rs2_addr,
    output cpu_pkg::id_ex_t                 id_ex
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic              is_op;
    logic              alu_ok;
    cpu_pkg::alu_op_e  alu_op;
    cpu_pkg::ctrl_t    ctrl;
    cpu_pkg::id_ex_t   id_ex_d;
    logic [cpu_pkg::XLEN-1:0] imm;

    assign opcode   = if_id_inst[6:0];
    assign funct3   = if_id_inst[14:12];
    assign funct7   = if_id_inst[31:25];
    assign rs1_addr = if_id_inst[19:15];
    assign rs2_addr = if_id_inst[24:20];
    assign is_op    = (opcode == cpu_pkg::OPC_OP);

    // shared by OP and OP_IMM; slt and shifts exist only in register form here
    always_comb begin
        alu_ok = 1'b1;
        alu_op = cpu_pkg::ALU_ADD;
        case (funct3)
            3'b000: alu_op = (is_op && funct7[5]) ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
            3'b111: alu_op = cpu_pkg::ALU_AND;
            3'b110: alu_op = cpu_pkg::ALU_OR;
            3'b100: alu_op = cpu_pkg::ALU_XOR;
            3'b010: alu_op = cpu_pkg::ALU_SLT;
            3'b001: alu_op = cpu_pkg::ALU_SLL;
            3'b101: alu_op = cpu_pkg::ALU_SRL;
            default: alu_ok = 1'b0;
        endcase
        if (!is_op && funct3 inside {3'b010, 3'b001, 3'b101}) begin
            alu_ok = 1'b0;
        end
        if (is_op && funct7 != 7'b0 && !(funct3 == 3'b000 && funct7 == 7'b0100000)) begin
            alu_ok = 1'b0;
        end
    end

    always_comb begin
        ctrl        = '0;   // anything unknown stays a nop
        ctrl.funct3 = funct3;
        case (opcode)
            cpu_pkg::OPC_OP: begin
                ctrl.reg_write = alu_ok;
                ctrl.alu_op    = alu_op;
            end
            cpu_pkg::OPC_OP_IMM: begin
                ctrl.reg_write   = alu_ok;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = alu_op;
            end
            cpu_pkg::OPC_LOAD: begin
                ctrl.reg_write   = (funct3 == 3'b011);   // ld only
                ctrl.mem_read    = (funct3 == 3'b011);
                ctrl.alu_src_imm = 1'b1;
                ctrl.wb_sel      = cpu_pkg::WB_MEM;
            end
            cpu_pkg::OPC_STORE: begin
                ctrl.mem_write   = (funct3 == 3'b011);   // sd only
                ctrl.alu_src_imm = 1'b1;
            end
            cpu_pkg::OPC_BRANCH: ctrl.branch = funct3 inside {3'b000, 3'b001, 3'b100, 3'b101};
            cpu_pkg::OPC_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jal       = 1'b1;
                ctrl.wb_sel    = cpu_pkg::WB_PC4;
            end
            cpu_pkg::OPC_JALR: begin
                ctrl.reg_write = (funct3 == 3'b000);
                ctrl.jalr      = (funct3 == 3'b000);
                ctrl.wb_sel    = cpu_pkg::WB_PC4;
            end
            cpu_pkg::OPC_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = cpu_pkg::WB_IMM;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (opcode)
            cpu_pkg::OPC_STORE:  imm = {{52{if_id_inst[31]}}, if_id_inst[31:25], if_id_inst[11:7]};
            cpu_pkg::OPC_BRANCH: imm = {{51{if_id_inst[31]}}, if_id_inst[31], if_id_inst[7],
                                        if_id_inst[30:25], if_id_inst[11:8], 1'b0};
            cpu_pkg::OPC_JAL:    imm = {{43{if_id_inst[31]}}, if_id_inst[31], if_id_inst[19:12],
                                        if_id_inst[20], if_id_inst[30:21], 1'b0};
            cpu_pkg::OPC_LUI:    imm = {{32{if_id_inst[31]}}, if_id_inst[31:12], 12'b0};
            default:             imm = {{52{if_id_inst[31]}}, if_id_inst[31:20]};
        endcase
    end

    always_comb begin
        id_ex_d.valid    = if_id_valid && !stall && !redirect;   // bubble
        id_ex_d.ctrl     = ctrl;
        id_ex_d.pc       = if_id_pc;
        id_ex_d.rs1      = rs1_addr;
        id_ex_d.rs2      = rs2_addr;
        id_ex_d.rd       = if_id_inst[11:7];
        id_ex_d.rs1_data = rs1_data;
        id_ex_d.rs2_data = rs2_data;
        id_ex_d.imm      = imm;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex <= id_ex_d;
        end
    end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            we,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]  waddr,
    input  logic [cpu_pkg::XLEN-1:0]        wdata,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]  raddr1,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]  raddr2,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]  debug_reg_addr,
    output logic [cpu_pkg::XLEN-1:0]        rdata1,
    output logic [cpu_pkg::XLEN-1:0]        rdata2,
    output logic [cpu_pkg::XLEN-1:0]        debug_reg_data
);

    logic [cpu_pkg::XLEN-1:0] regs [32];
    logic                     wr_en;

    assign wr_en = we && (waddr != '0);   // x0 never written

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wr_en) begin
            regs[waddr] <= wdata;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign rdata1         = (wr_en && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2         = (wr_en && waddr == raddr2) ? wdata : regs[raddr2];
    assign debug_reg_data = regs[debug_reg_addr];

endmodule

//--- logic/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit (
    input  logic [cpu_pkg::REG_ADDR_W-1:0]  id_ex_rs1,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]  id_ex_rs2,
    input  logic                            id_ex_mem_read,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]  id_ex_rd,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]  if_id_rs1,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]  if_id_rs2,
    input  logic                            ex_mem_reg_write,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]  ex_mem_rd,
    input  logic                            mem_wb_reg_write,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]  mem_wb_rd,
    output cpu_pkg::fwd_sel_e               fwd_a,
    output cpu_pkg::fwd_sel_e               fwd_b,
    output logic                            stall
);

    logic ex_fwd_ok;
    logic wb_fwd_ok;

    assign ex_fwd_ok = ex_mem_reg_write && (ex_mem_rd != '0);
    assign wb_fwd_ok = mem_wb_reg_write && (mem_wb_rd != '0);

    // the younger result in ex/mem wins
    assign fwd_a = (ex_fwd_ok && ex_mem_rd == id_ex_rs1) ? cpu_pkg::FWD_EX_MEM :
                   (wb_fwd_ok && mem_wb_rd == id_ex_rs1) ? cpu_pkg::FWD_WB : cpu_pkg::FWD_REG;
    assign fwd_b = (ex_fwd_ok && ex_mem_rd == id_ex_rs2) ? cpu_pkg::FWD_EX_MEM :
                   (wb_fwd_ok && mem_wb_rd == id_ex_rs2) ? cpu_pkg::FWD_WB : cpu_pkg::FWD_REG;

    assign stall = id_ex_mem_read && (id_ex_rd != '0) &&
                   (id_ex_rd == if_id_rs1 || id_ex_rd == if_id_rs2);   // load-use

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  cpu_pkg::id_ex_t             id_ex,
    input  cpu_pkg::fwd_sel_e           fwd_a,
    input  cpu_pkg::fwd_sel_e           fwd_b,
    input  logic [cpu_pkg::XLEN-1:0]    wb_data,
    output logic                        redirect,
    output logic [cpu_pkg::XLEN-1:0]    redirect_pc,
    output cpu_pkg::ex_mem_t            ex_mem
);

    logic [cpu_pkg::XLEN-1:0] op_a;
    logic [cpu_pkg::XLEN-1:0] rs2_fwd;
    logic [cpu_pkg::XLEN-1:0] op_b;
    logic [cpu_pkg::XLEN-1:0] alu_res;
    logic [cpu_pkg::XLEN-1:0] result;
    logic                     cond;
    cpu_pkg::ex_mem_t         ex_mem_d;

    always_comb begin
        case (fwd_a)
            cpu_pkg::FWD_EX_MEM: op_a = ex_mem.result;
            cpu_pkg::FWD_WB:     op_a = wb_data;
            default:             op_a = id_ex.rs1_data;
        endcase
        case (fwd_b)
            cpu_pkg::FWD_EX_MEM: rs2_fwd = ex_mem.result;
            cpu_pkg::FWD_WB:     rs2_fwd = wb_data;
            default:             rs2_fwd = id_ex.rs2_data;
        endcase
    end

    assign op_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : rs2_fwd;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            cpu_pkg::ALU_SUB: alu_res = op_a - op_b;
            cpu_pkg::ALU_AND: alu_res = op_a & op_b;
            cpu_pkg::ALU_OR:  alu_res = op_a | op_b;
            cpu_pkg::ALU_XOR: alu_res = op_a ^ op_b;
            cpu_pkg::ALU_SLT: alu_res = {63'b0, $signed(op_a) < $signed(op_b)};
            cpu_pkg::ALU_SLL: alu_res = op_a << op_b[5:0];
            cpu_pkg::ALU_SRL: alu_res = op_a >> op_b[5:0];
            default:          alu_res = op_a + op_b;
        endcase
    end

    always_comb begin
        case (id_ex.ctrl.funct3)
            3'b000:  cond = (op_a == rs2_fwd);
            3'b001:  cond = (op_a != rs2_fwd);
            3'b100:  cond = ($signed(op_a) < $signed(rs2_fwd));
            3'b101:  cond = ($signed(op_a) >= $signed(rs2_fwd));
            default: cond = 1'b0;
        endcase
    end

    assign redirect    = id_ex.valid &&
                         (id_ex.ctrl.jal || id_ex.ctrl.jalr || (id_ex.ctrl.branch && cond));
    assign redirect_pc = id_ex.ctrl.jalr ? ((op_a + id_ex.imm) & ~64'd1) : (id_ex.pc + id_ex.imm);

    // final value here so ex/mem forwarding is right for lui and links
    always_comb begin
        case (id_ex.ctrl.wb_sel)
            cpu_pkg::WB_IMM: result = id_ex.imm;
            cpu_pkg::WB_PC4: result = id_ex.pc + 64'd4;
            default:         result = alu_res;
        endcase
    end

    always_comb begin
        ex_mem_d.valid      = id_ex.valid;
        ex_mem_d.reg_write  = id_ex.ctrl.reg_write;
        ex_mem_d.mem_read   = id_ex.ctrl.mem_read;
        ex_mem_d.mem_write  = id_ex.ctrl.mem_write;
        ex_mem_d.wb_sel     = id_ex.ctrl.wb_sel;
        ex_mem_d.rd         = id_ex.rd;
        ex_mem_d.result     = result;
        ex_mem_d.store_data = rs2_fwd;
        ex_mem_d.pc         = id_ex.pc;
        ex_mem_d.imm        = id_ex.imm;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem <= ex_mem_d;
        end
    end

endmodule

//--- logic/writeback_stage.sv
`timescale 1ns/10ps

module writeback_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  cpu_pkg::ex_mem_t                ex_mem,
    input  logic [cpu_pkg::XLEN-1:0]        data_in,
    output logic                            reg_we,
    output logic [cpu_pkg::REG_ADDR_W-1:0]  reg_waddr,
    output logic [cpu_pkg::XLEN-1:0]        wb_data
);

    cpu_pkg::mem_wb_t mem_wb;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wb.valid <= 1'b0;
        end else begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.reg_write <= ex_mem.reg_write;
            mem_wb.wb_sel    <= ex_mem.wb_sel;
            mem_wb.rd        <= ex_mem.rd;
            mem_wb.result    <= ex_mem.result;
            mem_wb.pc        <= ex_mem.pc;
            mem_wb.imm       <= ex_mem.imm;
            if (ex_mem.valid && ex_mem.mem_read) begin
                mem_wb.load_data <= data_in;   // only loads sample the bus
            end
        end
    end

    assign reg_we    = mem_wb.valid & mem_wb.reg_write;
    assign reg_waddr = mem_wb.rd;

    always_comb begin
        case (mem_wb.wb_sel)
            cpu_pkg::WB_IMM: wb_data = mem_wb.imm;
            cpu_pkg::WB_PC4: wb_data = mem_wb.pc + 64'd4;
            cpu_pkg::WB_MEM: wb_data = mem_wb.load_data;
            default:         wb_data = mem_wb.result;
        endcase
    end

endmodule

//--- logic/scpu.sv
`timescale 1ns/10ps

module scpu (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [cpu_pkg::INST_W-1:0]      inst,
    input  logic [cpu_pkg::XLEN-1:0]        data_in,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]  debug_reg_addr,
    output logic [cpu_pkg::XLEN-1:0]        pc_out,
    output logic [cpu_pkg::XLEN-1:0]        addr_out,
    output logic [cpu_pkg::XLEN-1:0]        data_out,
    output logic                            mem_write,
    output logic [cpu_pkg::XLEN-1:0]        debug_reg_data
);

    logic                            stall;
    logic                            redirect;
    logic [cpu_pkg::XLEN-1:0]        redirect_pc;
    logic [cpu_pkg::INST_W-1:0]      if_id_inst;
    logic [cpu_pkg::XLEN-1:0]        if_id_pc;
    logic                            if_id_valid;
    logic [cpu_pkg::REG_ADDR_W-1:0]  rs1_addr;
    logic [cpu_pkg::REG_ADDR_W-1:0]  rs2_addr;
    logic [cpu_pkg::XLEN-1:0]        rs1_data;
    logic [cpu_pkg::XLEN-1:0]        rs2_data;
    cpu_pkg::id_ex_t                 id_ex;
    cpu_pkg::ex_mem_t                ex_mem;
    cpu_pkg::fwd_sel_e               fwd_a;
    cpu_pkg::fwd_sel_e               fwd_b;
    logic                            reg_we;
    logic [cpu_pkg::REG_ADDR_W-1:0]  reg_waddr;
    logic [cpu_pkg::XLEN-1:0]        wb_data;

    fetch_stage i_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .inst        (inst),
        .pc_out      (pc_out),
        .if_id_inst  (if_id_inst),
        .if_id_pc    (if_id_pc),
        .if_id_valid (if_id_valid)
    );

    decode_stage i_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .redirect    (redirect),
        .if_id_inst  (if_id_inst),
        .if_id_pc    (if_id_pc),
        .if_id_valid (if_id_valid),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .id_ex       (id_ex)
    );

    reg_file i_reg_file (
        .clk            (clk),
        .rst_n          (rst_n),
        .we             (reg_we),
        .waddr          (reg_waddr),
        .wdata          (wb_data),
        .raddr1         (rs1_addr),
        .raddr2         (rs2_addr),
        .debug_reg_addr (debug_reg_addr),
        .rdata1         (rs1_data),
        .rdata2         (rs2_data),
        .debug_reg_data (debug_reg_data)
    );

    hazard_unit i_hazard (
        .id_ex_rs1        (id_ex.rs1),
        .id_ex_rs2        (id_ex.rs2),
        .id_ex_mem_read   (id_ex.valid & id_ex.ctrl.mem_read),
        .id_ex_rd         (id_ex.rd),
        .if_id_rs1        (rs1_addr),
        .if_id_rs2        (rs2_addr),
        .ex_mem_reg_write (ex_mem.valid & ex_mem.reg_write),
        .ex_mem_rd        (ex_mem.rd),
        .mem_wb_reg_write (reg_we),
        .mem_wb_rd        (reg_waddr),
        .fwd_a            (fwd_a),
        .fwd_b            (fwd_b),
        .stall            (stall)
    );

    execute_stage i_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .id_ex       (id_ex),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .wb_data     (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ex_mem      (ex_mem)
    );

    writeback_stage i_writeback (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_mem    (ex_mem),
        .data_in   (data_in),
        .reg_we    (reg_we),
        .reg_waddr (reg_waddr),
        .wb_data   (wb_data)
    );

    // the memories answer in the same cycle so this stage is only ports
    assign addr_out  = ex_mem.result;
    assign data_out  = ex_mem.store_data;
    assign mem_write = ex_mem.valid & ex_mem.mem_write;

endmodule

//--- verif/tb_scpu.sv
`timescale 1ns/10ps

module tb_scpu;

    localparam int          CLK_PERIOD  = 100;
    localparam int          IMEM_DEPTH  = 64;
    localparam int          DMEM_DEPTH  = 64;
    localparam int          PROG_LEN    = 38;
    localparam int          CYCLE_LIMIT = 2 * PROG_LEN + 20;
    localparam logic [63:0] SELF_PC     = 64'd148;
    localparam logic [63:0] STORE_ADDR  = 64'h108;
    localparam logic [6:0]  OPC_OP_IMM  = 7'b0010011;
    localparam logic [6:0]  OPC_LOAD    = 7'b0000011;
    localparam logic [6:0]  OPC_JALR    = 7'b1100111;

    logic        clk;
    logic        rst_n;
    logic [31:0] inst;
    logic [63:0] data_in;
    logic [4:0]  debug_reg_addr;
    logic [63:0] pc_out;
    logic [63:0] addr_out;
    logic [63:0] data_out;
    logic        mem_write;
    logic [63:0] debug_reg_data;

    logic [31:0] imem [IMEM_DEPTH];
    logic [63:0] dmem [DMEM_DEPTH];
    logic [63:0] exp_reg [32];
    string       test_names [6];
    int          test_errs [6];
    int          checks;
    int          errors;
    int          stores_seen;
    int          cycles;
    logic        prog_done;
    integer      seed;

    scpu i_scpu (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst           (inst),
        .data_in        (data_in),
        .debug_reg_addr (debug_reg_addr),
        .pc_out         (pc_out),
        .addr_out       (addr_out),
        .data_out       (data_out),
        .mem_write      (mem_write),
        .debug_reg_data (debug_reg_data)
    );

    // both memories answer in the same cycle
    assign inst    = ((pc_out >> 2) < IMEM_DEPTH) ? imem[pc_out >> 2] : 32'h0;
    assign data_in = ((addr_out >> 3) < DMEM_DEPTH) ? dmem[addr_out >> 3] : 64'h0;

    always @(posedge clk) begin
        if (mem_write === 1'b1 && (addr_out >> 3) < DMEM_DEPTH) begin
            dmem[addr_out >> 3] <= data_out;
        end
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            if (rst_n && !prog_done) begin
                cycles++;
            end
        end
        $display("Timeout: the program did not reach its self-jump within %0d cycles",
                 CYCLE_LIMIT);
        $display("SIMULATION FAILED");
        $finish;
    end

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_i(input logic [6:0] opc, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encode_s(input logic [2:0] f3, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encode_b(input logic [2:0] f3, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encode_j(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] encode_u(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [11:0] imm);
        return encode_i(OPC_OP_IMM, 3'b000, rd, 5'd0, imm);
    endfunction

    task automatic load_program(input logic [11:0] imm_a, input logic [11:0] imm_b);
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            imem[i] = 32'h0;   // opcode 0 is a nop
        end
        imem[0]  = addi(5'd1, imm_a);
        imem[1]  = addi(5'd2, imm_b);
        imem[2]  = encode_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);    // add
        imem[3]  = encode_r(7'h20, 3'b000, 5'd4, 5'd3, 5'd1);    // sub
        imem[4]  = encode_r(7'h00, 3'b111, 5'd5, 5'd4, 5'd3);    // and
        imem[5]  = encode_r(7'h00, 3'b110, 5'd6, 5'd5, 5'd1);    // or
        imem[6]  = encode_r(7'h00, 3'b100, 5'd7, 5'd6, 5'd3);    // xor
        imem[7]  = encode_r(7'h00, 3'b010, 5'd8, 5'd1, 5'd2);    // slt
        imem[8]  = addi(5'd10, 12'd5);
        imem[9]  = encode_r(7'h00, 3'b001, 5'd9, 5'd7, 5'd10);   // sll
        imem[10] = encode_r(7'h00, 3'b101, 5'd11, 5'd9, 5'd10);  // srl
        imem[11] = encode_u(5'd12, 20'h8abcd);
        imem[12] = addi(5'd13, 12'h100);
        imem[13] = encode_s(3'b011, 5'd13, 5'd7, 12'd8);         // sd x7, 8(x13)
        imem[14] = encode_i(OPC_LOAD, 3'b011, 5'd14, 5'd13, 12'd8);
        imem[15] = encode_r(7'h00, 3'b000, 5'd15, 5'd14, 5'd1);  // load-use
        imem[16] = encode_b(3'b000, 5'd1, 5'd1, 13'd12);         // taken beq
        imem[17] = addi(5'd16, 12'd1);
        imem[18] = addi(5'd17, 12'd1);
        imem[19] = encode_b(3'b001, 5'd1, 5'd1, 13'd8);          // bne never taken
        imem[20] = addi(5'd18, 12'd1);
        imem[21] = encode_b(3'b100, 5'd1, 5'd2, 13'd12);         // blt
        imem[22] = addi(5'd19, 12'd1);
        imem[23] = addi(5'd20, 12'd1);
        imem[24] = encode_b(3'b101, 5'd1, 5'd2, 13'd12);         // bge
        imem[25] = addi(5'd21, 12'd1);
        imem[26] = addi(5'd22, 12'd1);
        imem[27] = encode_j(5'd23, 21'd12);
        imem[28] = addi(5'd24, 12'd1);
        imem[29] = addi(5'd25, 12'd1);
        imem[30] = addi(5'd26, 12'd7);                           // jal target marker
        imem[31] = addi(5'd28, 12'd140);
        imem[32] = encode_i(OPC_JALR, 3'b000, 5'd27, 5'd28, 12'd0);
        imem[33] = addi(5'd29, 12'd1);
        imem[34] = addi(5'd30, 12'd1);
        imem[35] = addi(5'd31, 12'd9);                           // jalr target marker
        imem[36] = addi(5'd0, 12'd5);
        imem[37] = encode_j(5'd0, 21'd0);                        // self-jump
    endtask

    task automatic compute_expected(input logic [63:0] a, input logic [63:0] b);
        logic a_lt_b;
        a_lt_b = $signed(a) < $signed(b);
        for (int r = 0; r < 32; r++) begin
            exp_reg[r] = 64'd0;
        end
        exp_reg[1]  = a;
        exp_reg[2]  = b;
        exp_reg[3]  = a + b;
        exp_reg[4]  = exp_reg[3] - a;
        exp_reg[5]  = exp_reg[4] & exp_reg[3];
        exp_reg[6]  = exp_reg[5] | a;
        exp_reg[7]  = exp_reg[6] ^ exp_reg[3];
        exp_reg[8]  = {63'd0, a_lt_b};
        exp_reg[10] = 64'd5;
        exp_reg[9]  = exp_reg[7] << 5;
        exp_reg[11] = exp_reg[9] >> 5;
        exp_reg[12] = 64'hffff_ffff_8abc_d000;   // lui sign-extends on rv64
        exp_reg[13] = 64'h100;
        exp_reg[14] = exp_reg[7];
        exp_reg[15] = exp_reg[7] + a;
        exp_reg[18] = 64'd1;
        exp_reg[19] = a_lt_b ? 64'd0 : 64'd1;
        exp_reg[20] = exp_reg[19];
        exp_reg[21] = a_lt_b ? 64'd1 : 64'd0;
        exp_reg[22] = exp_reg[21];
        exp_reg[23] = 64'd112;
        exp_reg[26] = 64'd7;
        exp_reg[27] = 64'd132;
        exp_reg[28] = 64'd140;
        exp_reg[31] = 64'd9;
    endtask

    task automatic check_eq(input int t, input string what, input logic [63:0] expected,
                            input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("Mismatch in %s, %s: expected %h, actual %h",
                     test_names[t], what, expected, actual);
            test_errs[t]++;
            errors++;
        end
    endtask

    task automatic read_reg(input int idx, output logic [63:0] value);
        @(negedge clk);
        debug_reg_addr = idx[4:0];
        #(CLK_PERIOD / 4);
        value = debug_reg_data;
    endtask

    task automatic check_regs(input int t, input int first, input int last);
        logic [63:0] value;
        for (int r = first; r <= last; r++) begin
            read_reg(r, value);
            check_eq(t, $sformatf("x%0d", r), exp_reg[r], value);
        end
    endtask

    task automatic finish_test(input int t);
        $display("test %0d %-15s %0s, %0d errors", t + 1, test_names[t],
                 (test_errs[t] == 0) ? "ok" : "failed", test_errs[t]);
    endtask

    // the one sd of the program
    always @(negedge clk) begin
        if (rst_n && mem_write === 1'b1) begin
            stores_seen++;
            check_eq(2, "store address", STORE_ADDR, addr_out);
            check_eq(2, "store data", exp_reg[7], data_out);
        end
    end

    initial begin
        int          ra;
        int          rb;
        logic [63:0] value;
        seed           = 86;
        rst_n          = 1'b0;
        debug_reg_addr = '0;
        prog_done      = 1'b0;
        checks         = 0;
        errors         = 0;
        stores_seen    = 0;
        test_names = '{"reset", "alu_forwarding", "load_store", "branches", "jumps",
                       "x0_writes"};
        for (int t = 0; t < 6; t++) begin
            test_errs[t] = 0;
        end
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i] = {~i, i};
        end
        ra = $random(seed) % 2048;   // fits the 12-bit addi immediate
        rb = $random(seed) % 2048;
        load_program(ra[11:0], rb[11:0]);
        compute_expected({{32{ra[31]}}, ra}, {{32{rb[31]}}, rb});

        repeat (3) begin
            @(negedge clk);
            check_eq(0, "pc_out in reset", 64'd0, pc_out);
            check_eq(0, "mem_write in reset", 64'd0, {63'd0, mem_write});
        end
        rst_n = 1'b1;
        #(CLK_PERIOD / 4);
        check_eq(0, "pc_out after reset", 64'd0, pc_out);
        check_eq(0, "mem_write after reset", 64'd0, {63'd0, mem_write});
        finish_test(0);

        while (pc_out !== SELF_PC) begin
            @(negedge clk);
        end
        prog_done = 1'b1;
        repeat (5) @(negedge clk);   // last instruction before the self-jump retires

        check_regs(1, 1, 12);
        finish_test(1);
        check_regs(2, 13, 15);
        checks++;
        assert (stores_seen == 1) else begin
            $display("The SD was seen %0d times at the data port instead of once",
                     stores_seen);
            test_errs[2]++;
            errors++;
        end
        finish_test(2);
        check_regs(3, 16, 22);
        finish_test(3);
        check_regs(4, 23, 31);
        finish_test(4);
        read_reg(0, value);
        check_eq(5, "x0", 64'd0, value);
        finish_test(5);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/hazard_unit.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/scpu.sv
verif/tb_scpu.sv

//--- Bender.yml
package:
  name: scpu

sources:
  - logic/cpu_pkg.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/reg_file.sv
  - logic/hazard_unit.sv
  - logic/execute_stage.sv
  - logic/writeback_stage.sv
  - logic/scpu.sv
  - target: simulation
    files:
      - verif/tb_scpu.sv
